/* run_sim.sh */
#!/bin/sh
# Compile and run the controller hub testbench with Verilator

BUILD_DIR=obj_dir
TOP=tb_controller_hub
LOG=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module "$TOP" \
	--Mdir "$BUILD_DIR" -o "$TOP" \
	-f sim.f
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation run returned status $status"
	exit 1
fi

if grep -q "^Simulation passed$" "$LOG"; then
	exit 0
else
	echo "No passing result found in $LOG"
	exit 1
fi

/* sim.f */
src/llapi_pkg.sv
src/llapi_frame_in.sv
src/pad_remap_stage.sv
src/slot_assign_out.sv
src/controller_hub_top.sv
verification/controller_hub_properties.sv
verification/tb_controller_hub.sv

/* src/controller_hub_top.sv */
// Top level: input, remap and slot stages of the player-controller path
`timescale 1ns/1ns

module controller_hub_top (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     serial_select,
	input  llapi_pkg::poll_frame_t   in_frame,
	input  logic                     in_valid,
	output logic                     in_ready,
	output llapi_pkg::player_frame_t out_frame,
	output logic                     out_valid,
	input  logic                     out_ready
);

	// Input stage to remap stage
	llapi_pkg::tracked_frame_t trk_frame;
	logic                      trk_valid;
	logic                      trk_ready;

	// Remap stage to output stage
	llapi_pkg::mapped_frame_t map_frame;
	logic                     map_valid;
	logic                     map_ready;

	llapi_frame_in u_frame_in (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.in_frame      (in_frame),
		.in_valid      (in_valid),
		.in_ready      (in_ready),
		.serial_select (serial_select),
		.trk_frame     (trk_frame),
		.trk_valid     (trk_valid),
		.trk_ready     (trk_ready)
	);

	pad_remap_stage u_remap (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.trk_frame (trk_frame),
		.trk_valid (trk_valid),
		.trk_ready (trk_ready),
		.map_frame (map_frame),
		.map_valid (map_valid),
		.map_ready (map_ready)
	);

	slot_assign_out u_slots (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.map_frame (map_frame),
		.map_valid (map_valid),
		.map_ready (map_ready),
		.out_frame (out_frame),
		.out_valid (out_valid),
		.out_ready (out_ready)
	);

endmodule

/* src/llapi_frame_in.sv */
// Input stage: poll frame register, per-port seen flags and presence decode
`timescale 1ns/1ns

module llapi_frame_in (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  llapi_pkg::poll_frame_t    in_frame,
	input  logic                      in_valid,
	output logic                      in_ready,
	input  logic                      serial_select,
	output llapi_pkg::tracked_frame_t trk_frame,
	output logic                      trk_valid,
	input  logic                      trk_ready
);

	logic accept;
	logic seen_a;
	logic seen_b;
	logic seen_a_next;
	logic seen_b_next;
	logic present_a;
	logic present_b;

	// Type 0 means no controller or an Atari pad, so a button press is needed
	function automatic logic port_present(
		input llapi_pkg::llapi_report_t rpt,
		input logic                     seen_now,
		input logic                     sel
	);
		logic typed;
		typed = |rpt.ctrl_type;
		return sel && rpt.enabled && (typed || seen_now);
	endfunction

	// Register empty or drained this cycle
	assign in_ready = !trk_valid || trk_ready;
	assign accept   = in_valid && in_ready;

	// Buttons of the current frame already count
	assign seen_a_next = seen_a || (|in_frame.report_a.buttons);
	assign seen_b_next = seen_b || (|in_frame.report_b.buttons);

	assign present_a = port_present(in_frame.report_a, seen_a_next, serial_select);
	assign present_b = port_present(in_frame.report_b, seen_b_next, serial_select);

	////////////////////////////////////////////////////////////
	// Seen flags, sticky until reset
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			seen_a <= 1'b0;
			seen_b <= 1'b0;
		end else if (accept) begin
			seen_a <= seen_a_next;
			seen_b <= seen_b_next;
		end
	end

	////////////////////////////////////////////////////////////
	// Stage register
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			trk_valid <= 1'b0;
		end else if (in_ready) begin
			trk_valid <= in_valid;
		end
	end

	// Payload only moves on a transfer
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			trk_frame.frame     <= in_frame;
			trk_frame.present_a <= present_a;
			trk_frame.present_b <= present_b;
		end
	end

endmodule

/* src/llapi_pkg.sv */
// Widths, button indices, controller type codes, slot mode enum and frame structs
package llapi_pkg;

	////////////////////////////////////////////////////////////
	// Widths and counts
	////////////////////////////////////////////////////////////
	localparam int LLAPI_BUTTON_W = 32;
	localparam int LLAPI_TYPE_W   = 8;
	localparam int PAD_W          = 12;
	localparam int USB_PADS       = 5;
	localparam int PLAYER_SLOTS   = 5;

	// Controller types that report a six-button pad
	localparam logic [5:0][LLAPI_TYPE_W-1:0] SIX_BUTTON_TYPES = {
		8'd20, 8'd21, 8'd8, 8'd3, 8'd54, 8'd11
	};

	////////////////////////////////////////////////////////////
	// Bit positions inside a serial report
	////////////////////////////////////////////////////////////
	localparam int BTN_A     = 0;
	localparam int BTN_B     = 1;
	localparam int BTN_X     = 2;
	localparam int BTN_Y     = 3;
	localparam int BTN_MODE  = 4;
	localparam int BTN_START = 5;
	localparam int BTN_Z     = 6;
	localparam int BTN_C     = 7;

	// Up, down, left, right sit in 27..24
	localparam int DPAD_LSB      = 24;
	localparam int MENU_BTN_DPAD = 26;

	////////////////////////////////////////////////////////////
	// Bit positions inside a console pad word
	////////////////////////////////////////////////////////////
	localparam int PAD_Z     = 11;
	localparam int PAD_Y     = 10;
	localparam int PAD_X     = 9;
	localparam int PAD_MODE  = 8;
	localparam int PAD_START = 7;
	localparam int PAD_C     = 6;
	localparam int PAD_B     = 5;
	localparam int PAD_A     = 4;

	typedef logic [PAD_W-1:0] pad_t;

	// How the serial pads share the player slots
	typedef enum logic [1:0] {
		SLOTS_USB_ONLY,
		SLOTS_ONE_SERIAL,
		SLOTS_TWO_SERIAL
	} slot_mode_e;

	////////////////////////////////////////////////////////////
	// Frames along the pipeline
	////////////////////////////////////////////////////////////
	typedef struct packed {
		logic [LLAPI_BUTTON_W-1:0] buttons;
		logic [LLAPI_TYPE_W-1:0]   ctrl_type;
		logic                      enabled;
	} llapi_report_t;

	typedef struct packed {
		llapi_report_t          report_a;
		llapi_report_t          report_b;
		pad_t [USB_PADS-1:0]    usb;
	} poll_frame_t;

	typedef struct packed {
		poll_frame_t frame;
		logic        present_a;
		logic        present_b;
	} tracked_frame_t;

	typedef struct packed {
		pad_t                pad_a;
		pad_t                pad_b;
		logic                present_a;
		logic                present_b;
		pad_t [USB_PADS-1:0] usb;
		logic                menu_combo;
	} mapped_frame_t;

	typedef struct packed {
		pad_t [PLAYER_SLOTS-1:0] slot;
		logic                    menu_combo;
	} player_frame_t;

endpackage

/* src/pad_remap_stage.sv */
// Remap stage: layout select by controller type, pad remap and menu combo detect
`timescale 1ns/1ns

module pad_remap_stage (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  llapi_pkg::tracked_frame_t trk_frame,
	input  logic                      trk_valid,
	output logic                      trk_ready,
	output llapi_pkg::mapped_frame_t  map_frame,
	output logic                      map_valid,
	input  logic                      map_ready
);

	logic            accept;
	logic            six_a;
	logic            six_b;
	llapi_pkg::pad_t pad_a;
	llapi_pkg::pad_t pad_b;
	logic            menu_combo;

	// Match against the six-button type list
	function automatic logic is_six_button(input logic [llapi_pkg::LLAPI_TYPE_W-1:0] ctype);
		logic hit;
		hit = 1'b0;
		for (int i = 0; i < 6; i++) begin
			if (ctype == llapi_pkg::SIX_BUTTON_TYPES[i]) begin
				hit = 1'b1;
			end
		end
		return hit;
	endfunction

	// Report buttons to console pad word
	function automatic llapi_pkg::pad_t remap(
		input logic [llapi_pkg::LLAPI_BUTTON_W-1:0] btn,
		input logic                                 six
	);
		llapi_pkg::pad_t pad;
		pad = '0;
		pad[llapi_pkg::PAD_Z]     = btn[llapi_pkg::BTN_Z];
		pad[llapi_pkg::PAD_Y]     = btn[llapi_pkg::BTN_Y];
		pad[llapi_pkg::PAD_MODE]  = btn[llapi_pkg::BTN_MODE];
		pad[llapi_pkg::PAD_START] = btn[llapi_pkg::BTN_START];
		if (six) begin
			pad[llapi_pkg::PAD_X] = btn[llapi_pkg::BTN_X];
			pad[llapi_pkg::PAD_C] = btn[llapi_pkg::BTN_C];
			pad[llapi_pkg::PAD_B] = btn[llapi_pkg::BTN_B];
			pad[llapi_pkg::PAD_A] = btn[llapi_pkg::BTN_A];
		end else begin
			// Face buttons rotate on the other layout
			pad[llapi_pkg::PAD_X] = btn[llapi_pkg::BTN_C];
			pad[llapi_pkg::PAD_C] = btn[llapi_pkg::BTN_B];
			pad[llapi_pkg::PAD_B] = btn[llapi_pkg::BTN_A];
			pad[llapi_pkg::PAD_A] = btn[llapi_pkg::BTN_X];
		end
		pad[3:0] = btn[llapi_pkg::DPAD_LSB +: 4];
		return pad;
	endfunction

	// Down + start + A opens the menu
	function automatic logic combo_hit(input logic [llapi_pkg::LLAPI_BUTTON_W-1:0] btn);
		return btn[llapi_pkg::MENU_BTN_DPAD] && btn[llapi_pkg::BTN_START] &&
			btn[llapi_pkg::BTN_A];
	endfunction

	assign trk_ready = !map_valid || map_ready;
	assign accept    = trk_valid && trk_ready;

	assign six_a = is_six_button(trk_frame.frame.report_a.ctrl_type);
	assign six_b = is_six_button(trk_frame.frame.report_b.ctrl_type);
	assign pad_a = remap(trk_frame.frame.report_a.buttons, six_a);
	assign pad_b = remap(trk_frame.frame.report_b.buttons, six_b);

	// Raw buttons, presence ignored
	assign menu_combo = combo_hit(trk_frame.frame.report_a.buttons) ||
		combo_hit(trk_frame.frame.report_b.buttons);

	////////////////////////////////////////////////////////////
	// Stage register
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			map_valid <= 1'b0;
		end else if (trk_ready) begin
			map_valid <= trk_valid;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (accept) begin
			map_frame.pad_a      <= pad_a;
			map_frame.pad_b      <= pad_b;
			map_frame.present_a  <= trk_frame.present_a;
			map_frame.present_b  <= trk_frame.present_b;
			map_frame.usb        <= trk_frame.frame.usb;
			map_frame.menu_combo <= menu_combo;
		end
	end

endmodule

/* src/slot_assign_out.sv */
// Output stage: slot mode decode, player slot assignment and output register
`timescale 1ns/1ns

module slot_assign_out (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  llapi_pkg::mapped_frame_t map_frame,
	input  logic                     map_valid,
	output logic                     map_ready,
	output llapi_pkg::player_frame_t out_frame,
	output logic                     out_valid,
	input  logic                     out_ready
);

	logic                                     accept;
	llapi_pkg::slot_mode_e                    mode;
	llapi_pkg::pad_t [llapi_pkg::PLAYER_SLOTS-1:0] slot;

	assign map_ready = !out_valid || out_ready;
	assign accept    = map_valid && map_ready;

	always_comb begin
		case ({map_frame.present_a, map_frame.present_b})
			2'b11:   mode = llapi_pkg::SLOTS_TWO_SERIAL;
			2'b10,
			2'b01:   mode = llapi_pkg::SLOTS_ONE_SERIAL;
			default: mode = llapi_pkg::SLOTS_USB_ONLY;
		endcase
	end

	// Serial pads take the first slots, USB pads shift up
	always_comb begin
		slot = map_frame.usb;
		case (mode)
			llapi_pkg::SLOTS_TWO_SERIAL: begin
				slot[0] = map_frame.pad_a;
				slot[1] = map_frame.pad_b;
				for (int i = 2; i < llapi_pkg::PLAYER_SLOTS; i++) begin
					slot[i] = map_frame.usb[i-2];
				end
			end
			llapi_pkg::SLOTS_ONE_SERIAL: begin
				// usb0 fills whichever of the first two slots is free
				slot[0] = map_frame.present_a ? map_frame.pad_a : map_frame.usb[0];
				slot[1] = map_frame.present_b ? map_frame.pad_b : map_frame.usb[0];
				for (int i = 2; i < llapi_pkg::PLAYER_SLOTS; i++) begin
					slot[i] = map_frame.usb[i-1];
				end
			end
			default: begin
				slot = map_frame.usb;
			end
		endcase
	end

	////////////////////////////////////////////////////////////
	// Output register, held while out_ready is low
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (map_ready) begin
			out_valid <= map_valid;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (accept) begin
			out_frame.slot       <= slot;
			out_frame.menu_combo <= map_frame.menu_combo;
		end
	end

endmodule

/* verification/controller_hub_properties.sv */
// Handshake stability, reset and presence assertions for the pipeline stages, with binds
`timescale 1ns/1ns

module controller_hub_properties (
	input logic         clk_sys,
	input logic         reset,
	input logic         valid,
	input logic         ready,
	input logic [159:0] data,
	input logic         present_a,
	input logic         present_b,
	input logic         serial_select
);

	////////////////////////////////////////////////////////////
	// Handshake
	////////////////////////////////////////////////////////////
	// A stalled frame keeps its valid and its payload
	property stall_holds;
		@(posedge clk_sys) disable iff (reset)
			valid && !ready |=> valid && $stable(data);
	endproperty

	property quiet_after_reset;
		@(posedge clk_sys) reset |=> !valid;
	endproperty

	// Presence needs the serial ports selected
	property present_needs_select;
		@(posedge clk_sys) disable iff (reset)
			valid && (present_a || present_b) |-> serial_select;
	endproperty

	stall_hold_chk: assert property (stall_holds)
		else $error("Valid or data changed while the frame was stalled");

	reset_quiet_chk: assert property (quiet_after_reset)
		else $error("Valid raised in the cycle after reset");

	present_sel_chk: assert property (present_needs_select)
		else $error("Port present while serial ports are deselected");

endmodule

bind llapi_frame_in controller_hub_properties u_in_props (
	.clk_sys       (clk_sys),
	.reset         (reset),
	.valid         (trk_valid),
	.ready         (trk_ready),
	.data          ({16'd0, trk_frame}),
	.present_a     (trk_frame.present_a),
	.present_b     (trk_frame.present_b),
	.serial_select (serial_select)
);

bind slot_assign_out controller_hub_properties u_out_props (
	.clk_sys       (clk_sys),
	.reset         (reset),
	.valid         (out_valid),
	.ready         (out_ready),
	.data          ({99'd0, out_frame}),
	.present_a     (1'b0),
	.present_b     (1'b0),
	.serial_select (1'b1)
);

/* verification/tb_controller_hub.sv */
// Testbench for the controller hub with stimulus, reference model, output checks and watchdog
`timescale 1ns/1ns

module tb_controller_hub;

	localparam int CLK_PERIOD    = 20;
	localparam int RESET_CYCLES  = 4;
	localparam int RANDOM_FRAMES = 300;
	// Frames sent by all tests together, and the number of resets
	localparam int TOTAL_FRAMES  = 1 + 11 + 4 + 6 + 8 + 6 + RANDOM_FRAMES;
	localparam int RESET_COUNT   = 5;
	localparam int TIMEOUT_NS    = TOTAL_FRAMES * CLK_PERIOD * 8 +
		RESET_COUNT * RESET_CYCLES * CLK_PERIOD;

	logic                     clk_sys;
	logic                     reset;
	logic                     serial_select;
	llapi_pkg::poll_frame_t   in_frame;
	logic                     in_valid;
	logic                     in_ready;
	llapi_pkg::player_frame_t out_frame;
	logic                     out_valid;
	logic                     out_ready;

	llapi_pkg::player_frame_t exp_q[$];
	llapi_pkg::player_frame_t want;
	logic                     ref_seen_a;
	logic                     ref_seen_b;
	logic [31:0]              rng_state;
	logic                     stall_en;
	int cyc = 0;
	int acc_cyc;
	int out_cyc;
	int cmp_errors = 0;
	int chk_errors = 0;
	int check_count = 0;
	int test_count;
	int failed_tests;
	int test_err_start;
	int test_chk_start;

	controller_hub_top DUT (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.serial_select (serial_select),
		.in_frame      (in_frame),
		.in_valid      (in_valid),
		.in_ready      (in_ready),
		.out_frame     (out_frame),
		.out_valid     (out_valid),
		.out_ready     (out_ready)
	);

	initial clk_sys = 1'b0;
	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cyc <= cyc + 1;
	end

	////////////////////////////////////////////////////////////
	// Random numbers and stimulus helpers
	////////////////////////////////////////////////////////////
	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	// Six-button codes first, then other nonzero types
	function automatic logic [7:0] layout_type(input int k);
		case (k)
			0:       return 8'd20;
			1:       return 8'd21;
			2:       return 8'd8;
			3:       return 8'd3;
			4:       return 8'd54;
			5:       return 8'd11;
			6:       return 8'd1;
			7:       return 8'd2;
			8:       return 8'd5;
			9:       return 8'd100;
			default: return 8'd255;
		endcase
	endfunction

	function automatic llapi_pkg::llapi_report_t make_report(
		input logic [31:0] buttons,
		input logic [7:0]  ctrl_type,
		input logic        enabled
	);
		llapi_pkg::llapi_report_t rpt;
		rpt.buttons   = buttons;
		rpt.ctrl_type = ctrl_type;
		rpt.enabled   = enabled;
		return rpt;
	endfunction

	function automatic llapi_pkg::poll_frame_t make_frame(
		input llapi_pkg::llapi_report_t rpt_a,
		input llapi_pkg::llapi_report_t rpt_b
	);
		llapi_pkg::poll_frame_t f;
		logic [31:0] r0;
		logic [31:0] r1;
		r0 = next_random();
		r1 = next_random();
		f.report_a = rpt_a;
		f.report_b = rpt_b;
		f.usb      = {r1[27:0], r0};
		return f;
	endfunction

	// Sparse buttons so the seen flags matter early on
	function automatic llapi_pkg::llapi_report_t random_report();
		logic [31:0] r;
		logic [31:0] btn;
		logic [7:0]  ctype;
		r     = next_random();
		btn   = (r[1:0] == 2'b00) ? 32'd0 : next_random();
		ctype = (r[3:2] == 2'b00) ? 8'd0 : layout_type(int'(r[15:8]) % 11);
		return make_report(btn, ctype, r[4] | r[5]);
	endfunction

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////
	function automatic logic six_button_type(input logic [7:0] t);
		case (t)
			8'd20, 8'd21, 8'd8, 8'd3, 8'd54, 8'd11: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic llapi_pkg::pad_t map_pad(input logic [31:0] btn, input logic six);
		llapi_pkg::pad_t pad;
		// Z Y X Mode Start C B A
		if (six) begin
			pad[11:4] = {btn[6], btn[3], btn[2], btn[4], btn[5], btn[7], btn[1], btn[0]};
		end else begin
			pad[11:4] = {btn[6], btn[3], btn[7], btn[4], btn[5], btn[1], btn[0], btn[2]};
		end
		pad[3:0] = btn[27:24];
		return pad;
	endfunction

	// Updates the model's seen flags, so call once per accepted frame in order
	function automatic llapi_pkg::player_frame_t expected_frame(
		input llapi_pkg::poll_frame_t f,
		input logic                   sel
	);
		llapi_pkg::player_frame_t res;
		llapi_pkg::pad_t          pad_a;
		llapi_pkg::pad_t          pad_b;
		logic                     pres_a;
		logic                     pres_b;
		ref_seen_a = ref_seen_a || (f.report_a.buttons != 32'd0);
		ref_seen_b = ref_seen_b || (f.report_b.buttons != 32'd0);
		pres_a = sel && f.report_a.enabled && (f.report_a.ctrl_type != 8'd0 || ref_seen_a);
		pres_b = sel && f.report_b.enabled && (f.report_b.ctrl_type != 8'd0 || ref_seen_b);
		pad_a  = map_pad(f.report_a.buttons, six_button_type(f.report_a.ctrl_type));
		pad_b  = map_pad(f.report_b.buttons, six_button_type(f.report_b.ctrl_type));
		res.menu_combo = (f.report_a.buttons[26] && f.report_a.buttons[5] &&
			f.report_a.buttons[0]) ||
			(f.report_b.buttons[26] && f.report_b.buttons[5] && f.report_b.buttons[0]);
		if (pres_a && pres_b) begin
			res.slot[0] = pad_a;
			res.slot[1] = pad_b;
			res.slot[2] = f.usb[0];
			res.slot[3] = f.usb[1];
			res.slot[4] = f.usb[2];
		end else if (pres_a || pres_b) begin
			res.slot[0] = pres_a ? pad_a : f.usb[0];
			res.slot[1] = pres_b ? pad_b : f.usb[0];
			res.slot[2] = f.usb[1];
			res.slot[3] = f.usb[2];
			res.slot[4] = f.usb[3];
		end else begin
			res.slot = f.usb;
		end
		return res;
	endfunction

	////////////////////////////////////////////////////////////
	// Driver tasks
	////////////////////////////////////////////////////////////
	task automatic next_cycle();
		logic [31:0] r;
		@(posedge clk_sys);
		#2;
		r = next_random();
		out_ready = stall_en ? (r[1:0] != 2'b00) : 1'b1;
	endtask

	task automatic apply_reset(input logic sel);
		in_valid      = 1'b0;
		reset         = 1'b1;
		serial_select = sel;
		ref_seen_a    = 1'b0;
		ref_seen_b    = 1'b0;
		repeat (RESET_CYCLES) next_cycle();
		reset = 1'b0;
	endtask

	// Inputs settle by the falling edge, so the transfer is decided there
	task automatic send_frame(input llapi_pkg::poll_frame_t f);
		logic taken;
		in_frame = f;
		in_valid = 1'b1;
		taken    = 1'b0;
		while (!taken) begin
			@(negedge clk_sys);
			taken = in_ready;
			if (taken) begin
				exp_q.push_back(expected_frame(f, serial_select));
				acc_cyc = cyc;
			end
			next_cycle();
		end
	endtask

	task automatic drain();
		in_valid = 1'b0;
		while (exp_q.size() != 0) begin
			next_cycle();
		end
		// Extra cycles catch a duplicated frame
		repeat (4) next_cycle();
	endtask

	task automatic start_test();
		test_err_start = cmp_errors + chk_errors;
		test_chk_start = check_count;
	endtask

	task automatic finish_test(input string name);
		int errs;
		drain();
		errs = cmp_errors + chk_errors - test_err_start;
		test_count++;
		if (errs != 0) begin
			failed_tests++;
		end
		$display("Test %0d %s: %0d frames checked, %0d errors", test_count, name,
			check_count - test_chk_start, errs);
	endtask

	////////////////////////////////////////////////////////////
	// Comparing process
	////////////////////////////////////////////////////////////
	always @(negedge clk_sys) begin
		if (!reset && out_valid && out_ready) begin
			assert (exp_q.size() != 0) else begin
				$display("Output frame at %0t ns arrived with no input frame pending", $time);
				cmp_errors++;
			end
			if (exp_q.size() != 0) begin
				want = exp_q.pop_front();
				check_count++;
				out_cyc = cyc;
				assert (out_frame === want) else begin
					$display("Error at %0t ns: frame %0d got %h, expected %h", $time,
						check_count, out_frame, want);
					cmp_errors++;
				end
			end
		end
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
		$display("Simulation failed");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////
	initial begin
		llapi_pkg::llapi_report_t rpt_a;
		llapi_pkg::llapi_report_t rpt_b;
		logic [31:0]              r;
		rng_state     = 32'd85;
		reset         = 1'b1;
		serial_select = 1'b1;
		in_frame      = '0;
		in_valid      = 1'b0;
		out_ready     = 1'b1;
		stall_en      = 1'b0;
		ref_seen_a    = 1'b0;
		ref_seen_b    = 1'b0;
		test_count    = 0;
		failed_tests  = 0;
		acc_cyc       = 0;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		#2;
		reset = 1'b0;

		start_test();
		@(negedge clk_sys);
		assert (!out_valid && in_ready) else begin
			$display("Error at %0t ns: after reset out_valid %b, in_ready %b", $time,
				out_valid, in_ready);
			chk_errors++;
		end
		next_cycle();
		send_frame(make_frame(make_report(next_random(), 8'd20, 1'b1),
			make_report(next_random(), 8'd20, 1'b1)));
		drain();
		assert (out_cyc - acc_cyc == 3) else begin
			$display("Error at %0t ns: latency %0d cycles, expected 3", $time,
				out_cyc - acc_cyc);
			chk_errors++;
		end
		finish_test("reset and latency");

		start_test();
		for (int k = 0; k < 11; k++) begin
			rpt_a = make_report(next_random(), layout_type(k), 1'b1);
			rpt_b = make_report(next_random(), layout_type((k + 5) % 11), 1'b1);
			send_frame(make_frame(rpt_a, rpt_b));
		end
		finish_test("controller layouts");

		// Port B only becomes present once a button is seen
		start_test();
		apply_reset(1'b1);
		rpt_a = make_report(next_random(), 8'd20, 1'b1);
		send_frame(make_frame(rpt_a, make_report(32'd0, 8'd0, 1'b1)));
		send_frame(make_frame(rpt_a, make_report(32'h0100_0000, 8'd0, 1'b1)));
		send_frame(make_frame(rpt_a, make_report(32'd0, 8'd0, 1'b1)));
		send_frame(make_frame(rpt_a, make_report(32'd0, 8'd0, 1'b1)));
		finish_test("presence by button press");

		start_test();
		apply_reset(1'b0);
		for (int k = 0; k < 6; k++) begin
			rpt_a = make_report(next_random(), layout_type(k), 1'b1);
			rpt_b = make_report(next_random(), layout_type(10 - k), 1'b1);
			send_frame(make_frame(rpt_a, rpt_b));
		end
		finish_test("serial ports deselected");

		start_test();
		apply_reset(1'b1);
		for (int k = 0; k < 4; k++) begin
			rpt_a = make_report(next_random(), 8'd3, 1'b1);
			rpt_b = make_report(next_random(), 8'd21, 1'b0);
			send_frame(make_frame(rpt_a, rpt_b));
		end
		for (int k = 0; k < 4; k++) begin
			rpt_a = make_report(next_random(), 8'd54, 1'b0);
			rpt_b = make_report(next_random(), 8'd8, 1'b1);
			send_frame(make_frame(rpt_a, rpt_b));
		end
		finish_test("single serial port");

		// Bits 26, 5 and 0 form the combo
		start_test();
		send_frame(make_frame(make_report(32'h0400_0021, 8'd20, 1'b1),
			make_report(32'd0, 8'd1, 1'b1)));
		send_frame(make_frame(make_report(32'd0, 8'd20, 1'b1),
			make_report(32'h0400_0021, 8'd1, 1'b0)));
		send_frame(make_frame(make_report(32'h0400_0020, 8'd20, 1'b1),
			make_report(32'h0000_0021, 8'd1, 1'b1)));
		send_frame(make_frame(make_report(32'h0000_0001, 8'd20, 1'b1),
			make_report(32'h0400_0001, 8'd1, 1'b1)));
		send_frame(make_frame(make_report(32'd0, 8'd20, 1'b1),
			make_report(32'd0, 8'd1, 1'b1)));
		send_frame(make_frame(make_report(32'hFFFF_FFFF, 8'd11, 1'b0),
			make_report(32'd0, 8'd0, 1'b0)));
		finish_test("menu combo");

		start_test();
		apply_reset(1'b1);
		stall_en = 1'b1;
		for (int n = 0; n < RANDOM_FRAMES; n++) begin
			r = next_random();
			if (r[2:0] == 3'b000) begin
				in_valid = 1'b0;
				next_cycle();
			end
			rpt_a = random_report();
			rpt_b = random_report();
			send_frame(make_frame(rpt_a, rpt_b));
		end
		finish_test("random frames with stalls");
		stall_en = 1'b0;

		$display("Tests run %0d, tests failed %0d, frames checked %0d, errors %0d",
			test_count, failed_tests, check_count, cmp_errors + chk_errors);
		if (cmp_errors + chk_errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule
